// File: Bender.yml
package:
  name: qdrc

sources:
  - files:
      - hw/qdrc_pkg.sv
      - hw/qdrc_cmd_sched.sv
      - hw/qdrc_lane.sv
      - hw/qdrc_rd_return.sv
      - hw/qdrc_top.sv
  - target: test
    files:
      - testbench/qdr_sram_model.sv
      - testbench/tb_qdrc_top.sv

// File: hw/qdrc_cmd_sched.sv
`timescale 1ns/10ps

module qdrc_cmd_sched (
  input  logic                clk0,
  input  logic                arst_n,
  input  logic                usr_rd_strb,
  input  logic                usr_wr_strb,
  input  qdrc_pkg::qdr_addr_t usr_addr,
  output qdrc_pkg::qdr_cmd_t  cmd,
  output logic                wr_go,
  output logic                rd_go,
  output logic                phy_rdy,
  output logic                qdr_dll_off_n
);
  import qdrc_pkg::*;

  sched_state_t          state;
  sched_state_t          state_nxt;
  logic [INIT_CNT_W-1:0] init_cnt;
  logic                  init_done;
  logic                  run;

  logic                  dll_off_n_q;
  logic                  rd_n_q;
  logic                  wr_n_q;
  qdr_addr_t             rd_addr_q;
  qdr_addr_t             wr_addr_q;

  // dll lock wait
  assign init_done = (init_cnt == INIT_CNT_W'(INIT_CYCLES - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      ST_INIT: begin
        if (init_done) begin
          state_nxt = ST_RUN;
        end
      end
      ST_RUN: begin
        state_nxt = ST_RUN;   // stays here until the next reset
      end
      default: begin
        state_nxt = ST_INIT;
      end
    endcase
  end

  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_INIT;
      init_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == ST_INIT) begin
        init_cnt <= init_cnt + 1'b1;
      end
    end
  end

  assign run     = (state == ST_RUN);
  assign phy_rdy = run;

  // accepted strobes, early ones are dropped
  assign rd_go = usr_rd_strb & run;
  assign wr_go = usr_wr_strb & run;   // lanes load the data in the same edge

  // sram dll is enabled once reset is gone
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      dll_off_n_q <= 1'b0;
    end else begin
      dll_off_n_q <= 1'b1;
    end
  end

  assign qdr_dll_off_n = dll_off_n_q;

  // command strobes, active low on the pins
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      rd_n_q <= 1'b1;
      wr_n_q <= 1'b1;
    end else begin
      rd_n_q <= ~rd_go;
      wr_n_q <= ~wr_go;
    end
  end

  // one address in, two address phases out
  always_ff @(posedge clk0) begin
    if (rd_go) begin
      rd_addr_q <= usr_addr;
    end
    if (wr_go) begin
      wr_addr_q <= usr_addr;
    end
  end

  assign cmd = '{
    rd_n:    rd_n_q,
    wr_n:    wr_n_q,
    rd_addr: rd_addr_q,
    wr_addr: wr_addr_q
  };

endmodule

// File: hw/qdrc_lane.sv
`timescale 1ns/10ps

module qdrc_lane (
  input  logic                              clk0,
  input  logic                              arst_n,
  input  logic                              wr_go,
  input  logic [2*qdrc_pkg::LANE_WIDTH-1:0] wr_data,   // {fall, rise}
  input  logic [1:0]                        wr_be,     // {fall, rise}, active high
  input  qdrc_pkg::lane_data_t              q_rise,
  input  qdrc_pkg::lane_data_t              q_fall,
  output qdrc_pkg::lane_wr_t                wr_beats,
  output qdrc_pkg::lane_rd_t                rd_beats
);
  import qdrc_pkg::*;

  lane_data_t d_rise_q;
  lane_data_t d_fall_q;
  logic       bw_n_rise_q;
  logic       bw_n_fall_q;
  lane_data_t q_rise_q;
  lane_data_t q_fall_q;

  // byte writes, held inactive between writes
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      bw_n_rise_q <= 1'b1;
      bw_n_fall_q <= 1'b1;
    end else if (wr_go) begin
      bw_n_rise_q <= ~wr_be[0];
      bw_n_fall_q <= ~wr_be[1];
    end else begin
      bw_n_rise_q <= 1'b1;
      bw_n_fall_q <= 1'b1;
    end
  end

  // write beats, meet the write cmd on the pins
  always_ff @(posedge clk0) begin
    if (wr_go) begin
      d_rise_q <= wr_data[LANE_WIDTH-1:0];
      d_fall_q <= wr_data[2*LANE_WIDTH-1:LANE_WIDTH];
    end
  end

  assign wr_beats = '{
    d_rise:    d_rise_q,
    d_fall:    d_fall_q,
    bw_n_rise: bw_n_rise_q,
    bw_n_fall: bw_n_fall_q
  };

  // read capture, free running
  always_ff @(posedge clk0) begin
    q_rise_q <= q_rise;
    q_fall_q <= q_fall;
  end

  assign rd_beats = '{
    q_rise: q_rise_q,
    q_fall: q_fall_q
  };

endmodule

// File: hw/qdrc_pkg.sv
package qdrc_pkg;

  // SRAM geometry
  localparam int DATA_WIDTH  = 18;
  localparam int BW_WIDTH    = 2;
  localparam int LANE_WIDTH  = DATA_WIDTH / BW_WIDTH;   // one byte lane incl. parity bit
  localparam int ADDR_WIDTH  = 21;

  // latencies in clk0 cycles
  localparam int QDR_LATENCY = 10;                      // usr_rd_strb to usr_rd_dvld
  localparam int SRAM_RD_LAT = 2;                       // read cmd on pins to qdr_q
  localparam int INIT_CYCLES = 64;                      // dll lock wait
  localparam int INIT_CNT_W  = $clog2(INIT_CYCLES);

  // cmd register + sram + lane capture register
  localparam int RD_CAPTURE_LAT = SRAM_RD_LAT + 2;
  // remaining delay after the capture tap
  localparam int RD_PIPE_DEPTH  = QDR_LATENCY - RD_CAPTURE_LAT;

  typedef logic [ADDR_WIDTH-1:0]   qdr_addr_t;
  typedef logic [2*DATA_WIDTH-1:0] qdr_word_t;   // {fall beat, rise beat}
  typedef logic [2*BW_WIDTH-1:0]   qdr_be_t;     // active high, rise lanes in low bits
  typedef logic [LANE_WIDTH-1:0]   lane_data_t;

  // read address rides the rising phase, write address the falling phase
  typedef struct packed {
    logic      rd_n;
    logic      wr_n;
    qdr_addr_t rd_addr;
    qdr_addr_t wr_addr;
  } qdr_cmd_t;

  typedef struct packed {
    lane_data_t d_rise;
    lane_data_t d_fall;
    logic       bw_n_rise;
    logic       bw_n_fall;
  } lane_wr_t;

  typedef struct packed {
    lane_data_t q_rise;
    lane_data_t q_fall;
  } lane_rd_t;

  typedef enum logic {
    ST_INIT,
    ST_RUN
  } sched_state_t;

endpackage

// File: hw/qdrc_rd_return.sv
`timescale 1ns/10ps

module qdrc_rd_return (
  input  logic                clk0,
  input  logic                arst_n,
  input  logic                rd_go,
  input  qdrc_pkg::lane_rd_t  lanes_rd [qdrc_pkg::BW_WIDTH],
  output qdrc_pkg::qdr_word_t usr_rd_data,
  output logic                usr_rd_dvld
);
  import qdrc_pkg::*;

  logic [QDR_LATENCY-1:0]  tag_sr;
  logic                    capture;
  logic [DATA_WIDTH-1:0]   join_rise;
  logic [DATA_WIDTH-1:0]   join_fall;
  qdr_word_t               join_word;
  qdr_word_t               data_pipe [RD_PIPE_DEPTH];

  // one tag per accepted read, bit k set k+1 cycles after the strobe
  always_ff @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      tag_sr <= '0;
    end else begin
      tag_sr <= {tag_sr[QDR_LATENCY-2:0], rd_go};
    end
  end

  // lane registers hold this read's beats now
  assign capture = tag_sr[RD_CAPTURE_LAT-1];

  always_comb begin
    join_rise = '0;
    join_fall = '0;
    for (int i = 0; i < BW_WIDTH; i++) begin
      join_rise[i*LANE_WIDTH +: LANE_WIDTH] = lanes_rd[i].q_rise;
      join_fall[i*LANE_WIDTH +: LANE_WIDTH] = lanes_rd[i].q_fall;
    end
  end

  assign join_word = {join_fall, join_rise};   // rise beat in the low half

  // latch at the tap, then plain delay up to QDR_LATENCY
  always_ff @(posedge clk0) begin
    if (capture) begin
      data_pipe[0] <= join_word;
    end
    for (int i = 1; i < RD_PIPE_DEPTH; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign usr_rd_data = data_pipe[RD_PIPE_DEPTH-1];
  assign usr_rd_dvld = tag_sr[QDR_LATENCY-1];

endmodule

// File: hw/qdrc_top.sv
`timescale 1ns/10ps

module qdrc_top (
  input  logic                           clk0,
  input  logic                           arst_n,
  // user side
  output logic                           phy_rdy,
  input  logic                           usr_rd_strb,
  input  logic                           usr_wr_strb,
  input  qdrc_pkg::qdr_addr_t            usr_addr,
  input  qdrc_pkg::qdr_word_t            usr_wr_data,
  input  qdrc_pkg::qdr_be_t              usr_wr_be,
  output qdrc_pkg::qdr_word_t            usr_rd_data,
  output logic                           usr_rd_dvld,
  // sram side, rise and fall vectors
  output qdrc_pkg::qdr_addr_t            qdr_sa_rise,
  output qdrc_pkg::qdr_addr_t            qdr_sa_fall,
  output logic                           qdr_r_n,
  output logic                           qdr_w_n,
  output logic                           qdr_dll_off_n,
  output logic [qdrc_pkg::DATA_WIDTH-1:0] qdr_d_rise,
  output logic [qdrc_pkg::DATA_WIDTH-1:0] qdr_d_fall,
  output logic [qdrc_pkg::BW_WIDTH-1:0]   qdr_bw_n_rise,
  output logic [qdrc_pkg::BW_WIDTH-1:0]   qdr_bw_n_fall,
  input  logic [qdrc_pkg::DATA_WIDTH-1:0] qdr_q_rise,
  input  logic [qdrc_pkg::DATA_WIDTH-1:0] qdr_q_fall
);
  import qdrc_pkg::*;

  qdr_cmd_t cmd;
  logic     wr_go;
  logic     rd_go;
  lane_wr_t lane_wr [BW_WIDTH];
  lane_rd_t lane_rd [BW_WIDTH];

  qdrc_cmd_sched u_cmd_sched (
    .clk0          (clk0),
    .arst_n        (arst_n),
    .usr_rd_strb   (usr_rd_strb),
    .usr_wr_strb   (usr_wr_strb),
    .usr_addr      (usr_addr),
    .cmd           (cmd),
    .wr_go         (wr_go),
    .rd_go         (rd_go),
    .phy_rdy       (phy_rdy),
    .qdr_dll_off_n (qdr_dll_off_n)
  );

  assign qdr_r_n     = cmd.rd_n;
  assign qdr_w_n     = cmd.wr_n;
  assign qdr_sa_rise = cmd.rd_addr;   // read address in rising phase
  assign qdr_sa_fall = cmd.wr_addr;   // write address in falling phase

  for (genvar i = 0; i < BW_WIDTH; i++) begin : lane_gen
    qdrc_lane u_lane (
      .clk0     (clk0),
      .arst_n   (arst_n),
      .wr_go    (wr_go),
      .wr_data  ({usr_wr_data[DATA_WIDTH + i*LANE_WIDTH +: LANE_WIDTH],
                  usr_wr_data[i*LANE_WIDTH +: LANE_WIDTH]}),
      .wr_be    ({usr_wr_be[BW_WIDTH + i], usr_wr_be[i]}),
      .q_rise   (qdr_q_rise[i*LANE_WIDTH +: LANE_WIDTH]),
      .q_fall   (qdr_q_fall[i*LANE_WIDTH +: LANE_WIDTH]),
      .wr_beats (lane_wr[i]),
      .rd_beats (lane_rd[i])
    );

    assign qdr_d_rise[i*LANE_WIDTH +: LANE_WIDTH] = lane_wr[i].d_rise;
    assign qdr_d_fall[i*LANE_WIDTH +: LANE_WIDTH] = lane_wr[i].d_fall;
    assign qdr_bw_n_rise[i]                       = lane_wr[i].bw_n_rise;
    assign qdr_bw_n_fall[i]                       = lane_wr[i].bw_n_fall;
  end

  qdrc_rd_return u_rd_return (
    .clk0        (clk0),
    .arst_n      (arst_n),
    .rd_go       (rd_go),
    .lanes_rd    (lane_rd),
    .usr_rd_data (usr_rd_data),
    .usr_rd_dvld (usr_rd_dvld)
  );

endmodule

// File: qdrc_top.f
hw/qdrc_pkg.sv
hw/qdrc_cmd_sched.sv
hw/qdrc_lane.sv
hw/qdrc_rd_return.sv
hw/qdrc_top.sv
testbench/qdr_sram_model.sv
testbench/tb_qdrc_top.sv

// File: testbench/qdr_sram_model.sv
`timescale 1ns/10ps

module qdr_sram_model (
  input  logic                            clk0,
  input  logic                            r_n,
  input  logic                            w_n,
  input  qdrc_pkg::qdr_addr_t             sa_rise,
  input  qdrc_pkg::qdr_addr_t             sa_fall,
  input  logic [qdrc_pkg::DATA_WIDTH-1:0] d_rise,
  input  logic [qdrc_pkg::DATA_WIDTH-1:0] d_fall,
  input  logic [qdrc_pkg::BW_WIDTH-1:0]   bw_n_rise,
  input  logic [qdrc_pkg::BW_WIDTH-1:0]   bw_n_fall,
  output logic [qdrc_pkg::DATA_WIDTH-1:0] q_rise,
  output logic [qdrc_pkg::DATA_WIDTH-1:0] q_fall
);
  import qdrc_pkg::*;

  localparam int MODEL_AW = 10;   // only the low address bits are decoded
  localparam int DEPTH    = 2**MODEL_AW;

  logic [DATA_WIDTH-1:0]   mem_rise [DEPTH];
  logic [DATA_WIDTH-1:0]   mem_fall [DEPTH];
  logic [2*DATA_WIDTH-1:0] rd_pipe  [SRAM_RD_LAT];

  // power-up contents, odd multipliers keep every address distinct
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem_rise[a] = DATA_WIDTH'(a * 32'h9e37 ^ 32'h155);
      mem_fall[a] = DATA_WIDTH'(~(a * 32'h6b43));
    end
  end

  always @(posedge clk0) begin
    logic [2*DATA_WIDTH-1:0] rd_word;
    logic [MODEL_AW-1:0]     ra;
    logic [MODEL_AW-1:0]     wa;
    ra      = sa_rise[MODEL_AW-1:0];
    wa      = sa_fall[MODEL_AW-1:0];
    rd_word = 'x;
    // read sees the contents before a write in the same cycle
    if (!r_n) begin
      rd_word = {mem_fall[ra], mem_rise[ra]};
    end
    if (!w_n) begin
      for (int i = 0; i < BW_WIDTH; i++) begin
        if (!bw_n_rise[i]) begin
          mem_rise[wa][i*LANE_WIDTH +: LANE_WIDTH] = d_rise[i*LANE_WIDTH +: LANE_WIDTH];
        end
        if (!bw_n_fall[i]) begin
          mem_fall[wa][i*LANE_WIDTH +: LANE_WIDTH] = d_fall[i*LANE_WIDTH +: LANE_WIDTH];
        end
      end
    end
    rd_pipe[0] <= rd_word;
    for (int k = 1; k < SRAM_RD_LAT; k++) begin
      rd_pipe[k] <= rd_pipe[k-1];
    end
  end

  assign q_rise = rd_pipe[SRAM_RD_LAT-1][DATA_WIDTH-1:0];
  assign q_fall = rd_pipe[SRAM_RD_LAT-1][2*DATA_WIDTH-1:DATA_WIDTH];

endmodule

// File: testbench/tb_qdrc_top.sv
`timescale 1ns/10ps

module tb_qdrc_top;
  import qdrc_pkg::*;

  localparam int          CLK_HALF = 2;
  localparam logic [31:0] SEED     = 32'h7e59_dacd;
  localparam int          TB_AW    = 6;   // 64 test addresses
  localparam int          N_FILL   = 2**TB_AW;
  localparam int          N_PAIR   = 8;
  localparam int          N_B2B    = 16;
  localparam int          N_RAND   = 400;
  localparam int          N_OPS    = N_FILL + 4*N_PAIR + N_B2B + N_RAND;
  localparam int          WD_CYCLES = 2000 + N_OPS*20;
  localparam int          ERR_RESET = 0;
  localparam int          ERR_PINS  = 1;
  localparam int          ERR_READ  = 2;

  logic                  clk0 = 1'b0;
  logic                  arst_n;
  logic                  usr_rd_strb;
  logic                  usr_wr_strb;
  qdr_addr_t             usr_addr;
  qdr_word_t             usr_wr_data;
  qdr_be_t               usr_wr_be;
  logic                  phy_rdy;
  qdr_word_t             usr_rd_data;
  logic                  usr_rd_dvld;
  qdr_addr_t             qdr_sa_rise;
  qdr_addr_t             qdr_sa_fall;
  logic                  qdr_r_n;
  logic                  qdr_w_n;
  logic                  qdr_dll_off_n;
  logic [DATA_WIDTH-1:0] qdr_d_rise;
  logic [DATA_WIDTH-1:0] qdr_d_fall;
  logic [BW_WIDTH-1:0]   qdr_bw_n_rise;
  logic [BW_WIDTH-1:0]   qdr_bw_n_fall;
  logic [DATA_WIDTH-1:0] qdr_q_rise;
  logic [DATA_WIDTH-1:0] qdr_q_fall;

  int          cyc = 0;       // posedges so far
  int          rel_cnt = 0;   // posedges since reset release
  int          err_cnt [3] = '{0, 0, 0};
  logic [31:0] rng;
  qdr_word_t   ref_mem [N_FILL];
  int          due_q [$];
  qdr_word_t   word_q [$];
  logic        exp_valid = 1'b0;
  qdr_word_t   exp_word;
  logic        rd_ok;
  logic        wr_ok;

  always #CLK_HALF clk0 = ~clk0;

  qdrc_top dut (.*);

  qdr_sram_model u_sram (
    .clk0      (clk0),
    .r_n       (qdr_r_n),
    .w_n       (qdr_w_n),
    .sa_rise   (qdr_sa_rise),
    .sa_fall   (qdr_sa_fall),
    .d_rise    (qdr_d_rise),
    .d_fall    (qdr_d_fall),
    .bw_n_rise (qdr_bw_n_rise),
    .bw_n_fall (qdr_bw_n_fall),
    .q_rise    (qdr_q_rise),
    .q_fall    (qdr_q_fall)
  );

  always @(posedge clk0) cyc <= cyc + 1;

  always @(posedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      rel_cnt <= 0;
    end else begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  // strobes the controller has to accept
  assign rd_ok = usr_rd_strb && (rel_cnt >= INIT_CYCLES);
  assign wr_ok = usr_wr_strb && (rel_cnt >= INIT_CYCLES);

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic roll(output logic [31:0] r);
    rng = lcg_step(rng);
    r   = rng;
  endtask

  // chunk k is lane k%BW of the rise (k<BW) or fall beat, enabled by be[k]
  function automatic qdr_word_t merge_be(qdr_word_t old_w, qdr_word_t new_w, qdr_be_t be);
    qdr_word_t res;
    res = old_w;
    for (int k = 0; k < 2*BW_WIDTH; k++) begin
      if (be[k]) begin
        res[k*LANE_WIDTH +: LANE_WIDTH] = new_w[k*LANE_WIDTH +: LANE_WIDTH];
      end
    end
    return res;
  endfunction

  task automatic count_error(input int kind, input string msg);
    err_cnt[kind]++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // one cycle of stimulus, reference model updated for accepted strobes
  task automatic drive(input logic rd, input logic wr, input qdr_addr_t addr,
                       input qdr_word_t data, input qdr_be_t be);
    @(negedge clk0);
    usr_rd_strb = rd;
    usr_wr_strb = wr;
    usr_addr    = addr;
    usr_wr_data = data;
    usr_wr_be   = be;
    if (rel_cnt >= INIT_CYCLES) begin
      if (rd) begin
        due_q.push_back(cyc + QDR_LATENCY);
        word_q.push_back(ref_mem[addr[TB_AW-1:0]]);   // old contents win
      end
      if (wr) begin
        ref_mem[addr[TB_AW-1:0]] = merge_be(ref_mem[addr[TB_AW-1:0]], data, be);
      end
    end
  endtask

  task automatic drive_random(input logic rd, input logic wr, input logic full_be,
                              input qdr_addr_t addr);
    logic [31:0] r0;
    logic [31:0] r1;
    roll(r0);
    roll(r1);
    drive(rd, wr, addr, {r1[3:0], r0}, full_be ? '1 : qdr_be_t'(r1[11:8]));
  endtask

  // expected read for the coming edge
  always @(negedge clk0) begin
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      exp_valid = 1'b1;
      exp_word  = word_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      exp_valid = 1'b0;
    end
  end

  a_reset_idle: assert property (@(posedge clk0) !arst_n && cyc > 0 |-> !phy_rdy
      && !usr_rd_dvld && qdr_r_n && qdr_w_n && !qdr_dll_off_n
      && &{qdr_bw_n_fall, qdr_bw_n_rise})
    else count_error(ERR_RESET, "outputs not idle during reset");
  a_phy_rdy: assert property (@(posedge clk0) arst_n |-> phy_rdy == (rel_cnt >= INIT_CYCLES))
    else count_error(ERR_RESET, $sformatf("phy_rdy=%0b at cycle %0d after reset",
                                          $sampled(phy_rdy), $sampled(rel_cnt)));
  a_dll_on: assert property (@(posedge clk0) rel_cnt > 0 |-> qdr_dll_off_n)
    else count_error(ERR_RESET, "qdr_dll_off_n low after reset");
  a_rd_cmd: assert property (@(posedge clk0) disable iff (!arst_n) qdr_r_n == !$past(rd_ok))
    else count_error(ERR_PINS, "qdr_r_n does not follow accepted read strobes");
  a_wr_cmd: assert property (@(posedge clk0) disable iff (!arst_n) qdr_w_n == !$past(wr_ok))
    else count_error(ERR_PINS, "qdr_w_n does not follow accepted write strobes");
  a_rd_addr: assert property (@(posedge clk0) disable iff (!arst_n)
      !qdr_r_n |-> qdr_sa_rise == $past(usr_addr))
    else count_error(ERR_PINS, "wrong read address on qdr_sa_rise");
  a_wr_beats: assert property (@(posedge clk0) disable iff (!arst_n)
      !qdr_w_n |-> qdr_sa_fall == $past(usr_addr)
      && {qdr_d_fall, qdr_d_rise} == $past(usr_wr_data)
      && {qdr_bw_n_fall, qdr_bw_n_rise} == ~$past(usr_wr_be))
    else count_error(ERR_PINS, "write address, beats or byte writes wrong on pins");
  a_bw_idle: assert property (@(posedge clk0) disable iff (!arst_n)
      qdr_w_n |-> &{qdr_bw_n_fall, qdr_bw_n_rise})
    else count_error(ERR_PINS, "byte writes active without a write");
  a_rd_latency: assert property (@(posedge clk0) disable iff (!arst_n)
      usr_rd_dvld == $past(rd_ok, QDR_LATENCY))
    else count_error(ERR_READ, "usr_rd_dvld not exactly QDR_LATENCY after a read");
  a_dvld_exp: assert property (@(posedge clk0) disable iff (!arst_n)
      usr_rd_dvld == exp_valid)
    else count_error(ERR_READ, $sformatf("usr_rd_dvld=%0b, expected %0b",
                                         $sampled(usr_rd_dvld), $sampled(exp_valid)));
  a_rd_data: assert property (@(posedge clk0) exp_valid |-> usr_rd_data == exp_word)
    else count_error(ERR_READ, $sformatf("read data 0x%h, expected 0x%h",
                                         $sampled(usr_rd_data), $sampled(exp_word)));

  initial begin
    repeat (WD_CYCLES) @(posedge clk0);
    $display("timeout: run still busy after %0d cycles", WD_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    qdr_addr_t   a;
    int          total;
    rng         = SEED;
    arst_n      = 1'b0;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    repeat (10) @(posedge clk0);
    @(negedge clk0);
    arst_n = 1'b1;

    // strobes during the dll wait must vanish
    for (int i = 0; i < INIT_CYCLES - 1; i++) begin
      roll(r);
      drive_random(r[0], r[1], 1'b0, qdr_addr_t'(r[13:8]));
    end
    while (rel_cnt < INIT_CYCLES) begin
      drive(1'b0, 1'b0, '0, '0, '0);
    end

    for (int i = 0; i < N_FILL; i++) begin
      drive_random(1'b0, 1'b1, 1'b1, qdr_addr_t'(i));
    end
    for (int i = 0; i < N_PAIR; i++) begin   // write then read
      roll(r);
      a = qdr_addr_t'(r[TB_AW-1:0]);
      drive_random(1'b0, 1'b1, 1'b1, a);
      drive_random(1'b1, 1'b0, 1'b1, a);
    end
    for (int i = 0; i < N_B2B; i++) begin
      drive_random(1'b1, 1'b0, 1'b1, qdr_addr_t'(i * 3));
    end
    for (int i = 0; i < N_PAIR; i++) begin   // read and write together, then read again
      roll(r);
      a = qdr_addr_t'(r[TB_AW-1:0]);
      drive_random(1'b1, 1'b1, 1'b1, a);
      drive_random(1'b1, 1'b0, 1'b1, a);
    end
    for (int i = 0; i < N_RAND; i++) begin
      roll(r);
      drive_random(r[0], r[1], r[2], qdr_addr_t'(r[TB_AW+7:8]));
    end

    while (due_q.size() > 0) begin
      drive(1'b0, 1'b0, '0, '0, '0);
    end
    repeat (QDR_LATENCY + 2) drive(1'b0, 1'b0, '0, '0, '0);

    total = err_cnt[ERR_RESET] + err_cnt[ERR_PINS] + err_cnt[ERR_READ];
    $display("errors: reset=%0d pins=%0d read=%0d total=%0d",
             err_cnt[ERR_RESET], err_cnt[ERR_PINS], err_cnt[ERR_READ], total);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
